// File: rv32_pkg.sv
package rv32_pkg;

    // ##################################################################
    // fixed sizes and addresses
    // ##################################################################

    localparam int          IMEM_WORDS   = 64;
    localparam int          IMEM_AW      = $clog2(IMEM_WORDS);  // word address width

    localparam logic [31:0] RESET_VECTOR = 32'h0000_0000;
    localparam logic [31:0] TRAP_VECTOR  = 32'h0000_00c0;       // word 48

    localparam logic [31:0] INSTR_NOP    = 32'h0000_0013;       // addi x0, x0, 0

    // funct3 values of the supported instructions
    localparam logic [2:0]  F3_ADDI      = 3'b000;
    localparam logic [2:0]  F3_BEQ       = 3'b000;
    localparam logic [2:0]  F3_BNE       = 3'b001;

    // ##################################################################
    // encodings
    // ##################################################################

    typedef enum logic [6:0] {
        OP_IMM    = 7'b0010011,
        OP_JAL    = 7'b1101111,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        KIND_ADDI,
        KIND_JAL,
        KIND_BEQ,
        KIND_BNE,
        KIND_ILLEGAL
    } instr_kind_e;

    // ##################################################################
    // stage records
    // ##################################################################

    // fetch -> execute
    typedef struct packed {
        logic        valid;
        logic        predicted_taken;
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_pkt_t;

    // execute -> fetch, one-cycle pulses
    typedef struct packed {
        logic        trap;
        logic        mispredict;
        logic [31:0] target;
    } redirect_t;

    // execute -> retire, and the registered record at the top
    typedef struct packed {
        logic        valid;
        logic        trap;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [4:0]  rd;        // zero when nothing is written
        logic [31:0] wb_value;
    } retire_t;

endpackage

// File: rv32_imem.sv
`timescale 1ns/10ps

module rv32_imem (
    input  logic                         clk,

    // load port
    input  logic                         load_en,
    input  logic [rv32_pkg::IMEM_AW-1:0] load_addr,
    input  logic [31:0]                  load_data,

    // fetch port
    input  logic [31:0]                  addr,
    output logic [31:0]                  data
);
    import rv32_pkg::*;

    logic [31:0]        mem [IMEM_WORDS];
    logic [IMEM_AW-1:0] word_idx;

    // byte address to word index, upper bits wrap
    assign word_idx = addr[IMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    assign data = mem[word_idx];  // asynchronous read

    // ##################################################################
    // checks
    // ##################################################################

    // fetch only ever produces word-aligned pcs
    a_addr_aligned: assert property (
        @(posedge clk) addr[1:0] == 2'b00
    ) else $error("imem fetch address %h not word aligned", addr);

endmodule

// File: rv32_fetch.sv
`timescale 1ns/10ps

module rv32_fetch (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 hold,

    // from execute
    input  rv32_pkg::redirect_t  redirect,

    // instruction memory
    output logic [31:0]          imem_addr,
    input  logic [31:0]          imem_data,

    // to execute
    output rv32_pkg::fetch_pkt_t fetch_pkt
);
    import rv32_pkg::*;

    logic [31:0] pc;
    logic [31:0] next_pc;
    logic        flush;

    opcode_e     opcode;
    logic        sign;
    logic [31:0] imm_j;
    logic [31:0] imm_b;
    logic        predict_taken;
    logic [31:0] pc_offset;

    assign imem_addr = pc;
    assign flush     = redirect.trap || redirect.mispredict;

    // ##################################################################
    // static prediction
    // ##################################################################

    assign opcode = opcode_e'(imem_data[6:0]);
    assign sign   = imem_data[31];
    assign imm_j  = {{12{sign}}, imem_data[19:12], imem_data[20], imem_data[30:21], 1'b0};
    assign imm_b  = {{20{sign}}, imem_data[7], imem_data[30:25], imem_data[11:8], 1'b0};

    always_comb begin
        predict_taken = 1'b0;
        pc_offset     = 32'd4;
        case (opcode)
            OP_JAL: begin
                predict_taken = 1'b1;
                pc_offset     = imm_j;
            end
            OP_BRANCH: begin
                if (sign) begin         // backward branch
                    predict_taken = 1'b1;
                    pc_offset     = imm_b;
                end
            end
            default: ;
        endcase

        if (flush) begin
            next_pc = redirect.target;  // trap already selected in execute
        end else begin
            next_pc = pc + pc_offset;
        end
    end

    // ##################################################################
    // pc and fetch register
    // ##################################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            pc                        <= RESET_VECTOR;
            fetch_pkt.valid           <= 1'b0;
            fetch_pkt.predicted_taken <= 1'b0;
            fetch_pkt.pc              <= '0;
            fetch_pkt.instr           <= INSTR_NOP;
        end else if (!hold) begin
            pc <= next_pc;
            if (flush) begin
                fetch_pkt.valid           <= 1'b0;  // one bubble
                fetch_pkt.predicted_taken <= 1'b0;
                fetch_pkt.pc              <= '0;
                fetch_pkt.instr           <= INSTR_NOP;
            end else begin
                fetch_pkt.valid           <= 1'b1;
                fetch_pkt.predicted_taken <= predict_taken;
                fetch_pkt.pc              <= pc;
                fetch_pkt.instr           <= imem_data;
            end
        end
    end

    // a redirect under hold would be lost, execute only fires on unheld cycles
    a_no_redirect_under_hold: assert property (
        @(posedge clk) disable iff (reset)
        hold |-> !flush
    ) else $error("redirect raised while the pipeline is held");

endmodule

// File: rv32_execute.sv
`timescale 1ns/10ps

module rv32_execute (
    input  rv32_pkg::fetch_pkt_t fetch_pkt,
    input  logic                 hold,

    // register file read
    output logic [4:0]           rs1_idx,
    output logic [4:0]           rs2_idx,
    input  logic [31:0]          rs1_data,
    input  logic [31:0]          rs2_data,

    // to fetch and retire
    output rv32_pkg::redirect_t  redirect,
    output rv32_pkg::retire_t    wb
);
    import rv32_pkg::*;

    logic [31:0] instr;
    logic [31:0] pc;
    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] pc_plus4;
    logic [31:0] branch_target;

    instr_kind_e kind;
    logic        is_ctrl;
    logic        taken;
    logic [31:0] resolved_pc;
    logic        fire;

    assign instr    = fetch_pkt.instr;
    assign pc       = fetch_pkt.pc;
    assign opcode   = opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign rd       = instr[11:7];
    assign rs1_idx  = instr[19:15];
    assign rs2_idx  = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc + imm_b;
    assign fire          = fetch_pkt.valid && !hold;  // redirects only leave when not held

    // ##################################################################
    // decode and branch resolution
    // ##################################################################

    always_comb begin
        case (opcode)
            OP_IMM:    kind = (funct3 == F3_ADDI) ? KIND_ADDI : KIND_ILLEGAL;
            OP_JAL:    kind = KIND_JAL;
            OP_BRANCH: begin
                if (funct3 == F3_BEQ) begin
                    kind = KIND_BEQ;
                end else if (funct3 == F3_BNE) begin
                    kind = KIND_BNE;
                end else begin
                    kind = KIND_ILLEGAL;
                end
            end
            default:   kind = KIND_ILLEGAL;
        endcase
    end

    always_comb begin
        is_ctrl     = 1'b0;
        taken       = 1'b0;
        resolved_pc = pc_plus4;
        case (kind)
            KIND_JAL: begin
                is_ctrl     = 1'b1;
                taken       = 1'b1;
                resolved_pc = pc + imm_j;
            end
            KIND_BEQ, KIND_BNE: begin
                is_ctrl     = 1'b1;
                taken       = (rs1_data == rs2_data) ^ (kind == KIND_BNE);
                resolved_pc = taken ? branch_target : pc_plus4;
            end
            default: ;
        endcase
    end

    always_comb begin
        redirect.trap       = fire && (kind == KIND_ILLEGAL);
        redirect.mispredict = fire && is_ctrl && (taken != fetch_pkt.predicted_taken);
        redirect.target     = (kind == KIND_ILLEGAL) ? TRAP_VECTOR : resolved_pc;
    end

    // ##################################################################
    // result record
    // ##################################################################

    always_comb begin
        wb.valid    = fetch_pkt.valid;
        wb.trap     = fetch_pkt.valid && (kind == KIND_ILLEGAL);
        wb.pc       = pc;
        wb.instr    = instr;
        wb.rd       = '0;                   // branches and traps write nothing
        wb.wb_value = '0;
        case (kind)
            KIND_ADDI: begin
                wb.rd       = rd;
                wb.wb_value = rs1_data + imm_i;
            end
            KIND_JAL: begin
                wb.rd       = rd;
                wb.wb_value = pc_plus4;         // link
            end
            default: ;
        endcase
    end

endmodule

// File: rv32_retire.sv
`timescale 1ns/10ps

module rv32_retire (
    input  logic              clk,
    input  logic              reset,
    input  logic              hold,

    // from execute
    input  rv32_pkg::retire_t wb,
    input  logic [4:0]        rs1_idx,
    input  logic [4:0]        rs2_idx,
    output logic [31:0]       rs1_data,
    output logic [31:0]       rs2_data,

    // registered record
    output rv32_pkg::retire_t retire
);
    logic [31:0] regs [32];
    logic        wr_en;

    assign wr_en = wb.valid && !wb.trap && (wb.rd != 5'd0) && !hold;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
            retire <= '0;
        end else begin
            if (wr_en) begin
                regs[wb.rd] <= wb.wb_value;
            end
            if (!hold) begin
                retire <= wb;   // frozen while held
            end
        end
    end

    // x0 reads as zero
    assign rs1_data = (rs1_idx == 5'd0) ? 32'd0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == 5'd0) ? 32'd0 : regs[rs2_idx];

    // ##################################################################
    // checks
    // ##################################################################

    a_trap_no_write: assert property (
        @(posedge clk) disable iff (reset)
        retire.valid && retire.trap |-> retire.rd == 5'd0
    ) else $error("trap record at pc %h names rd %0d", retire.pc, retire.rd);

endmodule

// File: rv32_frontend_top.sv
`timescale 1ns/10ps

module rv32_frontend_top (
    input  logic                         clk,
    input  logic                         reset,

    // program load
    input  logic                         load_en,
    input  logic [rv32_pkg::IMEM_AW-1:0] load_addr,
    input  logic [31:0]                  load_data,

    input  logic                         hold,
    output rv32_pkg::retire_t            retire
);
    import rv32_pkg::*;

    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    fetch_pkt_t  fetch_pkt;
    redirect_t   redirect;
    retire_t     wb;
    logic [4:0]  rs1_idx;
    logic [4:0]  rs2_idx;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;

    rv32_imem u_imem (
        .clk       (clk),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .addr      (imem_addr),
        .data      (imem_data)
    );

    rv32_fetch u_fetch (
        .clk       (clk),
        .reset     (reset),
        .hold      (hold),
        .redirect  (redirect),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .fetch_pkt (fetch_pkt)
    );

    rv32_execute u_execute (
        .fetch_pkt (fetch_pkt),
        .hold      (hold),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .redirect  (redirect),
        .wb        (wb)
    );

    rv32_retire u_retire (
        .clk       (clk),
        .reset     (reset),
        .hold      (hold),
        .wb        (wb),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .retire    (retire)
    );

endmodule

// File: tb_rv32_frontend.sv
`timescale 1ns/10ps

module tb_rv32_frontend;
    import rv32_pkg::*;

    localparam int PERIOD  = 40;
    localparam int MAX_REC = 128;

    logic               clk;
    logic               reset;
    logic               load_en;
    logic [IMEM_AW-1:0] load_addr;
    logic [31:0]        load_data;
    logic               hold;
    retire_t            retire;

    logic [31:0] prog [IMEM_WORDS];
    retire_t     exp_rec [MAX_REC];
    retire_t     exp_cur;
    int          exp_count;
    int          exp_idx;         // next expected record
    logic [31:0] halt_pc;
    logic [31:0] halt_word;
    logic        hold_q;          // hold as seen by the previous edge
    logic        new_rec;
    int          since_release;
    time         deadline;
    logic [31:0] lcg_state;

    rv32_frontend_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .hold      (hold),
        .retire    (retire)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // ##################################################################
    // stimulus helpers
    // ##################################################################

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_imm();
        return int'(next_random() % 32'd2048) - 1024;  // 12 bit signed range
    endfunction

    function automatic logic [31:0] enc_addi(logic [4:0] rd, logic [4:0] rs1, int imm);
        logic [11:0] i12;
        i12 = imm[11:0];
        return {i12, rs1, F3_ADDI, rd, OP_IMM};
    endfunction

    function automatic logic [31:0] enc_jal(logic [4:0] rd, int off);
        logic [20:0] o;
        o = off[20:0];
        return {o[20], o[10:1], o[11], o[19:12], rd, OP_JAL};
    endfunction

    function automatic logic [31:0] enc_branch(logic [2:0] f3, logic [4:0] rs1,
                                              logic [4:0] rs2, int off);
        logic [12:0] o;
        o = off[12:0];
        return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], OP_BRANCH};
    endfunction

    task automatic build_program(int which);
        int r;
        int n;
        r = rand_imm();
        n = 2 + int'(next_random() % 32'd4);  // loop trip count
        for (int i = 0; i < IMEM_WORDS; i++) begin
            prog[i[IMEM_AW-1:0]] = enc_addi(5'd0, 5'd0, i);  // addi x0, x0, word index
        end
        case (which)
            1: begin
                prog[0] = enc_addi(5'd1, 5'd0, r);
                prog[1] = enc_addi(5'd2, 5'd1, rand_imm());
                prog[2] = enc_addi(5'd0, 5'd2, 5);
                prog[3] = enc_addi(5'd3, 5'd0, rand_imm());
                prog[4] = enc_addi(5'd3, 5'd3, -1);
                prog[5] = enc_addi(5'd4, 5'd3, rand_imm());
                prog[6] = enc_jal(5'd0, 0);
            end
            2: begin
                prog[0] = enc_addi(5'd1, 5'd0, r);
                prog[1] = enc_jal(5'd5, 16);          // forward to word 5
                prog[2] = enc_addi(5'd2, 5'd5, 0);
                prog[3] = enc_jal(5'd0, 12);          // over the dead word
                prog[4] = enc_addi(5'd1, 5'd1, 100);  // never retires
                prog[5] = enc_jal(5'd6, -12);         // back to word 2
                prog[6] = enc_addi(5'd3, 5'd6, r);
                prog[7] = enc_jal(5'd0, 0);
            end
            3: begin
                prog[0]  = enc_addi(5'd1, 5'd0, r);
                prog[1]  = enc_addi(5'd2, 5'd0, r);
                prog[2]  = enc_branch(F3_BEQ, 5'd1, 5'd2, 12);   // forward taken
                prog[3]  = enc_addi(5'd7, 5'd0, 99);
                prog[4]  = enc_addi(5'd7, 5'd0, 98);
                prog[5]  = enc_addi(5'd3, 5'd0, 0);
                prog[6]  = enc_addi(5'd4, 5'd0, n);
                prog[7]  = enc_addi(5'd3, 5'd3, 1);               // loop body
                prog[8]  = enc_addi(5'd4, 5'd4, -1);
                prog[9]  = enc_branch(F3_BNE, 5'd4, 5'd0, -8);
                prog[10] = enc_branch(F3_BNE, 5'd1, 5'd2, -40);  // backward, not taken
                prog[11] = enc_addi(5'd5, 5'd3, 0);
                prog[12] = enc_jal(5'd0, 0);
            end
            default: begin
                prog[0]  = enc_addi(5'd1, 5'd0, r);
                prog[1]  = 32'h0000_1037;                         // lui, not supported
                prog[2]  = enc_addi(5'd1, 5'd0, 55);
                prog[48] = enc_addi(5'd2, 5'd1, 1);               // trap handler
                prog[49] = enc_jal(5'd0, 0);
            end
        endcase
    endtask

    // ##################################################################
    // reference model, one instruction per step
    // ##################################################################

    task automatic run_reference();
        logic [31:0] x [32];
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] next_pc;
        logic [31:0] imm;
        retire_t     rec;
        x         = '{default: '0};
        pc        = RESET_VECTOR;
        exp_count = 0;
        halt_pc   = '1;
        halt_word = '0;
        while (exp_count < MAX_REC && halt_pc == '1) begin
            w         = prog[pc[IMEM_AW+1:2]];
            rec       = '0;
            rec.valid = 1'b1;
            rec.pc    = pc;
            rec.instr = w;
            next_pc   = pc + 32'd4;
            if (w[6:0] == OP_IMM && w[14:12] == F3_ADDI) begin
                imm          = {{20{w[31]}}, w[31:20]};
                rec.rd       = w[11:7];
                rec.wb_value = x[w[19:15]] + imm;
            end else if (w[6:0] == OP_JAL) begin
                imm          = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                rec.rd       = w[11:7];
                rec.wb_value = pc + 32'd4;
                next_pc      = pc + imm;
            end else if (w[6:0] == OP_BRANCH && w[14:13] == 2'b00) begin
                imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                if ((x[w[19:15]] == x[w[24:20]]) != w[12]) begin  // bit 12 flips beq to bne
                    next_pc = pc + imm;
                end
            end else begin
                rec.trap = 1'b1;
                next_pc  = TRAP_VECTOR;
            end
            if (!rec.trap && rec.rd != 5'd0) begin
                x[rec.rd] = rec.wb_value;
            end
            exp_rec[exp_count[6:0]] = rec;
            exp_count++;
            if (next_pc == pc) begin  // jump to self ends the program
                halt_pc   = pc;
                halt_word = w;
            end
            pc = next_pc;
        end
    endtask

    // ##################################################################
    // checking
    // ##################################################################

    task automatic report_mismatch(string msg);
        $display("ERR %0t %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "retire record mismatch");
    endtask

    task automatic report_failure(string msg);
        $display("%s (at %0t)", msg, $time);
        $display("Test failures found");
        $fatal(1, "test aborted");
    endtask

    assign new_rec = retire.valid && !hold_q;  // retire only loads on unheld edges

    always_comb begin
        exp_cur = exp_rec[exp_idx[6:0]];
    end

    always @(posedge clk) begin
        hold_q <= hold;
        if (reset) begin
            exp_idx       <= 0;
            since_release <= 0;
        end else begin
            if (new_rec) begin
                exp_idx <= exp_idx + 1;
            end
            if ((!hold || since_release != 0) && since_release < 255) begin
                since_release <= since_release + 1;
            end
        end
    end

    a_record_matches: assert property (
        @(posedge clk) disable iff (reset)
        new_rec && exp_idx < exp_count |-> retire == exp_cur
    ) else report_mismatch({
        $sformatf("record %0d got pc %h instr %h rd %0d value %h trap %b",
            $sampled(exp_idx), $sampled(retire.pc), $sampled(retire.instr),
            $sampled(retire.rd), $sampled(retire.wb_value), $sampled(retire.trap)),
        $sformatf(", expected pc %h instr %h rd %0d value %h trap %b",
            $sampled(exp_cur.pc), $sampled(exp_cur.instr), $sampled(exp_cur.rd),
            $sampled(exp_cur.wb_value), $sampled(exp_cur.trap))});

    // past the end only the halt jump may keep retiring
    a_no_extra: assert property (
        @(posedge clk) disable iff (reset)
        new_rec && exp_idx >= exp_count |-> retire.pc == halt_pc && retire.instr == halt_word
    ) else report_mismatch($sformatf("extra record pc %h instr %h after the program end",
        $sampled(retire.pc), $sampled(retire.instr)));

    a_first_empty: assert property (
        @(posedge clk) disable iff (reset)
        since_release == 1 |-> !retire.valid
    ) else report_failure("a record retired one edge after release, one edge too early");

    a_first_on_time: assert property (
        @(posedge clk) disable iff (reset)
        since_release == 2 |-> retire.valid && retire.pc == RESET_VECTOR
    ) else report_failure("the first instruction did not retire two edges after release");

    always @(posedge clk) begin
        if ($time > deadline) begin
            report_failure("watchdog expired, the retire records stopped before the program end");
        end
    end

    // ##################################################################
    // test sequence
    // ##################################################################

    task automatic run_program(int which, bit with_holds);
        int c;
        @(posedge clk);
        reset <= 1'b1;
        hold  <= 1'b1;
        @(posedge clk);
        build_program(which);
        run_reference();
        deadline = $time + time'((8 + IMEM_WORDS + 40 * exp_count) * PERIOD);
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= IMEM_AW'(i);
            load_data <= prog[i[IMEM_AW-1:0]];
        end
        @(posedge clk);
        load_en <= 1'b0;
        hold    <= 1'b0;
        c = 0;
        while (exp_idx < exp_count) begin
            @(posedge clk);
            c++;
            if (with_holds) begin
                // cycle 3 holds the first branch while it sits in execute
                hold <= (c == 3) || (c > 3 && next_random() % 32'd4 == 32'd0);
            end
        end
        hold <= 1'b0;
        repeat (6) @(posedge clk);  // let the halt spin a little
    endtask

    initial begin
        reset     = 1'b1;
        hold      = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        lcg_state = 32'h27a;
        exp_count = 0;
        deadline  = time'(100 * PERIOD);
        run_program(1, 1'b0);
        run_program(2, 1'b0);
        run_program(3, 1'b0);
        run_program(4, 1'b0);
        run_program(3, 1'b1);
        run_program(2, 1'b1);
        run_program(4, 1'b1);
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: build.f
rv32_pkg.sv
rv32_imem.sv
rv32_fetch.sv
rv32_execute.sv
rv32_retire.sv
rv32_frontend_top.sv
tb_rv32_frontend.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the rv32 frontend testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_rv32_frontend \
    -f build.f \
    --Mdir obj_dir -o tb_rv32_frontend
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit $status
fi

./obj_dir/tb_rv32_frontend
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished cleanly"
exit 0
